// File: Bender.yml
package:
  name: cnn_quad

export_include_dirs:
  - logic

sources:
  - logic/quad_job_pkg.sv
  - logic/quad_data_pkg.sv
  - logic/quad_job_ctrl.sv
  - logic/quad_pixel_window.sv
  - logic/quad_mac_pipe.sv
  - logic/cnn_quad_top.sv
  - target: test
    files:
      - test/quad_clock_gen.sv
      - test/quad_sva.sv
      - test/quad_tb.sv

// File: logic/cnn_quad_top.sv
`timescale 1ns/1ps

module cnn_quad_top (
    input  logic                        clk_core,
    input  logic                        rst,
    input  logic                        job_start,
    input  quad_job_pkg::job_params_t   job_parameters,
    output logic                        job_accept,
    output logic                        job_complete,
    input  logic                        job_complete_ack,
    input  logic                        weight_valid,
    input  quad_data_pkg::weight_set_t  weight_data,
    output logic                        weight_ready,
    input  logic                        pixel_valid,
    input  quad_data_pkg::pixel_t       pixel_data,
    output logic                        pixel_ready,
    output logic                        result_valid,
    output quad_data_pkg::result_t      result_data
);

    logic                   pixel_take;
    logic                   job_clear;
    logic                   relu_enable;
    logic                   weight_load;
    logic                   window_valid;
    logic                   window_busy;
    logic                   mac_busy;
    quad_data_pkg::window_t window;

    quad_job_ctrl job_ctrl_i (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_parameters   (job_parameters),
        .job_complete_ack (job_complete_ack),
        .weight_valid     (weight_valid),
        .pixel_valid      (pixel_valid),
        .window_busy      (window_busy),
        .mac_busy         (mac_busy),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .weight_ready     (weight_ready),
        .weight_load      (weight_load),
        .pixel_ready      (pixel_ready),
        .pixel_take       (pixel_take),
        .job_clear        (job_clear),
        .relu_enable      (relu_enable)
    );

    quad_pixel_window pixel_window_i (
        .clk_core     (clk_core),
        .rst          (rst),
        .job_clear    (job_clear),
        .relu_enable  (relu_enable),
        .pixel_take   (pixel_take),
        .pixel_data   (pixel_data),
        .window_valid (window_valid),
        .window       (window),
        .window_busy  (window_busy)
    );

    quad_mac_pipe mac_pipe_i (
        .clk_core     (clk_core),
        .rst          (rst),
        .weight_load  (weight_load),
        .weight_data  (weight_data),
        .window_valid (window_valid),
        .window       (window),
        .result_valid (result_valid),
        .result_data  (result_data),
        .mac_busy     (mac_busy)
    );

endmodule

// File: logic/quad_data_pkg.sv
`include "quad_macros.svh"

package quad_data_pkg;

    //////////////////////////////
    // Scalar samples
    //////////////////////////////

    typedef logic signed [`QUAD_PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [`QUAD_WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [`QUAD_RESULT_WIDTH-1:0] result_t;

    //////////////////////////////
    // Kernel and window
    //////////////////////////////

    // w0 applies to the oldest pixel
    typedef struct packed {
        weight_t w0;
        weight_t w1;
        weight_t w2;
    } weight_set_t;

    // p_new is the pixel taken most recently
    typedef struct packed {
        pixel_t p_old;
        pixel_t p_mid;
        pixel_t p_new;
    } window_t;

    //////////////////////////////
    // Pipeline stages
    //////////////////////////////

    // Full-precision 8x8 products
    typedef struct packed {
        logic                                                   valid;
        logic signed [`QUAD_PIXEL_WIDTH+`QUAD_WEIGHT_WIDTH-1:0] prod0;
        logic signed [`QUAD_PIXEL_WIDTH+`QUAD_WEIGHT_WIDTH-1:0] prod1;
        logic signed [`QUAD_PIXEL_WIDTH+`QUAD_WEIGHT_WIDTH-1:0] prod2;
    } product_stage_t;

    // Two guard bits so three products never wrap
    typedef struct packed {
        logic                               valid;
        logic signed [`QUAD_RESULT_WIDTH+1:0] sum;
    } sum_stage_t;

endpackage

// File: logic/quad_job_ctrl.sv
`timescale 1ns/1ps

`include "quad_macros.svh"

module quad_job_ctrl (
    input  logic                      clk_core,
    input  logic                      rst,
    input  logic                      job_start,
    input  quad_job_pkg::job_params_t job_parameters,
    input  logic                      job_complete_ack,
    input  logic                      weight_valid,
    input  logic                      pixel_valid,
    input  logic                      window_busy,
    input  logic                      mac_busy,
    output logic                      job_accept,
    output logic                      job_complete,
    output logic                      weight_ready,
    output logic                      weight_load,
    output logic                      pixel_ready,
    output logic                      pixel_take,
    output logic                      job_clear,
    output logic                      relu_enable
);

    quad_job_pkg::ctrl_state_t    state;
    quad_job_pkg::job_params_t    job_q;
    logic [`QUAD_COUNT_WIDTH-1:0] pixel_count;
    logic                         count_done;
    logic                         start_seen;
    logic                         pipe_empty;

    //////////////////////////////
    // Host handshakes
    //////////////////////////////

    assign start_seen = (state == quad_job_pkg::ST_IDLE) && job_start;
    assign count_done = (pixel_count == job_q.num_pixels);
    assign pipe_empty = !window_busy && !mac_busy;

    // Kernel can only change between jobs
    assign weight_ready = weight_valid && (state == quad_job_pkg::ST_IDLE);
    assign weight_load  = weight_valid && weight_ready;

    assign pixel_ready = (state == quad_job_pkg::ST_ACTIVE) &&
                         (pixel_count < job_q.num_pixels);
    assign pixel_take  = pixel_valid && pixel_ready;

    assign job_complete = (state == quad_job_pkg::ST_COMPLETE);
    assign job_clear    = job_accept;
    assign relu_enable  = job_q.relu_enable;

    // Job parameters captured with the start
    always_ff @(posedge clk_core) begin
        if (start_seen) begin
            job_q <= job_parameters;
        end
    end

    //////////////////////////////
    // Job FSM
    //////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state       <= quad_job_pkg::ST_IDLE;
            job_accept  <= 1'b0;
            pixel_count <= '0;
        end else begin
            job_accept <= 1'b0;

            if (pixel_take) begin
                pixel_count <= pixel_count + 1'b1;
            end

            case (state)
                quad_job_pkg::ST_IDLE: begin
                    if (job_start) begin
                        state       <= quad_job_pkg::ST_ACTIVE;
                        job_accept  <= 1'b1;
                        pixel_count <= '0;
                    end
                end

                // Leaves one cycle after the last pixel, once window_busy covers it
                quad_job_pkg::ST_ACTIVE: begin
                    if (count_done) begin
                        state <= quad_job_pkg::ST_DRAIN;
                    end
                end

                quad_job_pkg::ST_DRAIN: begin
                    if (pipe_empty) begin
                        state <= quad_job_pkg::ST_COMPLETE;
                    end
                end

                quad_job_pkg::ST_COMPLETE: begin
                    if (job_complete_ack) begin
                        state <= quad_job_pkg::ST_IDLE;
                    end
                end

                default: begin
                    state <= quad_job_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/quad_job_pkg.sv
`include "quad_macros.svh"

package quad_job_pkg;

    //////////////////////////////
    // Job parameters
    //////////////////////////////

    // Sampled once, at job accept
    typedef struct packed {
        logic [`QUAD_COUNT_WIDTH-1:0] num_pixels;
        logic                         relu_enable;
    } job_params_t;

    //////////////////////////////
    // Controller states
    //////////////////////////////

    typedef enum logic [1:0] {
        // Waiting for job_start, kernel may be loaded
        ST_IDLE     = 2'd0,
        // Taking pixels
        ST_ACTIVE   = 2'd1,
        // Last pixel taken, pipeline still busy
        ST_DRAIN    = 2'd2,
        // Holding job_complete for the host
        ST_COMPLETE = 2'd3
    } ctrl_state_t;

endpackage

// File: logic/quad_mac_pipe.sv
`timescale 1ns/1ps

`include "quad_macros.svh"

module quad_mac_pipe (
    input  logic                        clk_core,
    input  logic                        rst,
    input  logic                        weight_load,
    input  quad_data_pkg::weight_set_t  weight_data,
    input  logic                        window_valid,
    input  quad_data_pkg::window_t      window,
    output logic                        result_valid,
    output quad_data_pkg::result_t      result_data,
    output logic                        mac_busy
);

    localparam int RES_W = `QUAD_RESULT_WIDTH;
    localparam int SUM_W = RES_W + 2;

    quad_data_pkg::weight_set_t     kernel_q;
    quad_data_pkg::product_stage_t  prod_q;
    quad_data_pkg::sum_stage_t      sum_q;
    quad_data_pkg::result_t         sat_value;
    logic [SUM_W-RES_W:0]           guard_bits;

    // Kernel register
    always_ff @(posedge clk_core) begin
        if (weight_load) begin
            kernel_q <= weight_data;
        end
    end

    //////////////////////////////
    // Multiply and sum
    //////////////////////////////

    always_ff @(posedge clk_core) begin
        prod_q.prod0 <= $signed(kernel_q.w0) * $signed(window.p_old);
        prod_q.prod1 <= $signed(kernel_q.w1) * $signed(window.p_mid);
        prod_q.prod2 <= $signed(kernel_q.w2) * $signed(window.p_new);
        if (rst) begin
            prod_q.valid <= 1'b0;
        end else begin
            prod_q.valid <= window_valid;
        end
    end

    always_ff @(posedge clk_core) begin
        sum_q.sum <= $signed(prod_q.prod0) + $signed(prod_q.prod1) + $signed(prod_q.prod2);
        if (rst) begin
            sum_q.valid <= 1'b0;
        end else begin
            sum_q.valid <= prod_q.valid;
        end
    end

    //////////////////////////////
    // Saturation
    //////////////////////////////

    // Sum fits when the guard bits all match the result sign
    assign guard_bits = sum_q.sum[SUM_W-1:RES_W-1];

    always_comb begin
        if ((&guard_bits) || !(|guard_bits)) begin
            sat_value = sum_q.sum[RES_W-1:0];
        end else if (sum_q.sum[SUM_W-1]) begin
            sat_value = {1'b1, {(RES_W-1){1'b0}}};
        end else begin
            sat_value = {1'b0, {(RES_W-1){1'b1}}};
        end
    end

    always_ff @(posedge clk_core) begin
        result_data <= sat_value;
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sum_q.valid;
        end
    end

    // Output register is not counted, its strobe is already visible
    assign mac_busy = prod_q.valid || sum_q.valid;

endmodule

// File: logic/quad_macros.svh
`ifndef QUAD_MACROS_SVH
`define QUAD_MACROS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Signed input pixel
`define QUAD_PIXEL_WIDTH 8

// Signed kernel weight
`define QUAD_WEIGHT_WIDTH 8

// Saturated output sample
`define QUAD_RESULT_WIDTH 16

//////////////////////////////
// Counts
//////////////////////////////

// Taps in the sliding window
`define QUAD_NUM_TAPS 3

// Pixel count of one job
`define QUAD_COUNT_WIDTH 10

`endif

// File: logic/quad_pixel_window.sv
`timescale 1ns/1ps

`include "quad_macros.svh"

module quad_pixel_window (
    input  logic                    clk_core,
    input  logic                    rst,
    input  logic                    job_clear,
    input  logic                    relu_enable,
    input  logic                    pixel_take,
    input  quad_data_pkg::pixel_t   pixel_data,
    output logic                    window_valid,
    output quad_data_pkg::window_t  window,
    output logic                    window_busy
);

    // Earlier pixels needed before a window is complete
    localparam logic [1:0] FULL_FILL = 2'(`QUAD_NUM_TAPS - 1);

    quad_data_pkg::pixel_t relu_pixel;
    logic [1:0]            fill_count;

    // ReLU zeroes anything with the sign bit set
    assign relu_pixel = (relu_enable && pixel_data[`QUAD_PIXEL_WIDTH-1]) ? '0 : pixel_data;

    // Shift register, oldest pixel drops out
    always_ff @(posedge clk_core) begin
        if (pixel_take) begin
            window.p_old <= window.p_mid;
            window.p_mid <= window.p_new;
            window.p_new <= relu_pixel;
        end
    end

    //////////////////////////////
    // Fill tracking
    //////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            fill_count   <= '0;
            window_valid <= 1'b0;
            window_busy  <= 1'b0;
        end else begin
            window_busy <= window_valid;
            if (job_clear) begin
                // A pixel taken alongside the clear is the first of the new job
                fill_count   <= pixel_take ? 2'd1 : 2'd0;
                window_valid <= 1'b0;
            end else begin
                window_valid <= pixel_take && (fill_count == FULL_FILL);
                if (pixel_take && (fill_count != FULL_FILL)) begin
                    fill_count <= fill_count + 2'd1;
                end
            end
        end
    end

endmodule

// File: sources.f
+incdir+logic
logic/quad_job_pkg.sv
logic/quad_data_pkg.sv
logic/quad_job_ctrl.sv
logic/quad_pixel_window.sv
logic/quad_mac_pipe.sv
logic/cnn_quad_top.sv
test/quad_clock_gen.sv
test/quad_sva.sv
test/quad_tb.sv

// File: test/quad_clock_gen.sv
`timescale 1ns/1ps

module quad_clock_gen (
    output logic clk_core,
    output logic rst
);

    localparam int HALF_PERIOD_NS = 50;
    localparam int RESET_CYCLES   = 3;

    initial begin
        clk_core = 1'b0;
        forever #(HALF_PERIOD_NS) clk_core = ~clk_core;
    end

    // Released just after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_core);
        #1;
        rst = 1'b0;
    end

endmodule

// File: test/quad_sva.sv
`timescale 1ns/1ps

module quad_sva (
    input logic clk_core,
    input logic rst,
    input logic job_accept,
    input logic job_complete,
    input logic job_complete_ack,
    input logic pixel_ready,
    input logic weight_ready,
    input logic result_valid,
    input logic pixel_take,
    input logic window_valid
);

    int   fail_count = 0;
    logic job_open;

    // From the accept pulse up to the acknowledged completion
    always_ff @(posedge clk_core) begin
        if (rst) begin
            job_open <= 1'b0;
        end else if (job_complete && job_complete_ack) begin
            job_open <= 1'b0;
        end else if (job_accept) begin
            job_open <= 1'b1;
        end
    end

    //////////////////////////////
    // Reset and job protocol
    //////////////////////////////

    reset_idle: assert property (@(posedge clk_core)
        rst |=> !job_accept && !job_complete && !pixel_ready && !weight_ready && !result_valid)
        else begin
            fail_count++;
            $error("Outputs active after a reset cycle");
        end

    accept_pulse: assert property (@(posedge clk_core) disable iff (rst)
        job_accept |=> !job_accept)
        else begin
            fail_count++;
            $error("job_accept longer than one cycle");
        end

    complete_hold: assert property (@(posedge clk_core) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else begin
            fail_count++;
            $error("job_complete dropped before the acknowledge");
        end

    complete_release: assert property (@(posedge clk_core) disable iff (rst)
        job_complete && job_complete_ack |=> !job_complete)
        else begin
            fail_count++;
            $error("job_complete still high after the acknowledge");
        end

    no_pixels_when_done: assert property (@(posedge clk_core) disable iff (rst)
        job_complete |-> !pixel_ready)
        else begin
            fail_count++;
            $error("pixel_ready high together with job_complete");
        end

    weights_locked: assert property (@(posedge clk_core) disable iff (rst)
        (job_accept || job_open) |-> !weight_ready)
        else begin
            fail_count++;
            $error("weight_ready high during a job");
        end

    //////////////////////////////
    // Pipeline latency
    //////////////////////////////

    window_to_result: assert property (@(posedge clk_core) disable iff (rst)
        window_valid |-> ##3 result_valid)
        else begin
            fail_count++;
            $error("Window without a result three cycles later");
        end

    // Three cycles after the edge that took the closing pixel
    result_latency: assert property (@(posedge clk_core) disable iff (rst)
        result_valid |-> $past(pixel_take, 4) && $past(window_valid, 3))
        else begin
            fail_count++;
            $error("Result not three cycles after its pixel");
        end

endmodule

bind cnn_quad_top quad_sva quad_sva_i (
    .clk_core         (clk_core),
    .rst              (rst),
    .job_accept       (job_accept),
    .job_complete     (job_complete),
    .job_complete_ack (job_complete_ack),
    .pixel_ready      (pixel_ready),
    .weight_ready     (weight_ready),
    .result_valid     (result_valid),
    .pixel_take       (pixel_take),
    .window_valid     (window_valid)
);

// File: test/quad_tb.sv
`timescale 1ns/1ps

`include "quad_macros.svh"

module quad_tb;

    localparam int WAIT_LIMIT  = 200;
    localparam int CYCLE_LIMIT = 5000;

    logic                       clk_core;
    logic                       rst;
    logic                       job_start;
    quad_job_pkg::job_params_t  job_parameters;
    logic                       job_accept;
    logic                       job_complete;
    logic                       job_complete_ack;
    logic                       weight_valid;
    quad_data_pkg::weight_set_t weight_data;
    logic                       weight_ready;
    logic                       pixel_valid;
    quad_data_pkg::pixel_t      pixel_data;
    logic                       pixel_ready;
    logic                       result_valid;
    quad_data_pkg::result_t     result_data;

    integer                     seed;
    int                         errors;
    int                         tests_run;
    int                         tests_bad;
    int                         errors_before;
    int                         kern[0:2];
    int                         pix[0:15];
    quad_data_pkg::result_t     expected_q[$];
    quad_data_pkg::result_t     exp_val;

    quad_clock_gen clock_gen_i (
        .clk_core (clk_core),
        .rst      (rst)
    );

    cnn_quad_top cnn_quad_top_i (.*);

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk_core);
        #1;
    endtask

    function automatic int total_errors();
        return errors + cnn_quad_top_i.quad_sva_i.fail_count;
    endfunction

    function automatic int rand_byte();
        logic signed [7:0] b;
        b = 8'($random(seed));
        return int'(b);
    endfunction

    function automatic logic watched_signal(input int sel);
        case (sel)
            0: return weight_ready;
            1: return pixel_ready;
            2: return job_accept;
            3: return job_complete;
            default: return !rst;
        endcase
    endfunction

    // Samples mid-cycle, then moves past the edge that acts on it
    task automatic wait_for(input int sel, input string what);
        int waited;
        waited = 0;
        @(negedge clk_core);
        while (watched_signal(sel) !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk_core);
            waited++;
        end
        if (watched_signal(sel) !== 1'b1) begin
            $display("Timed out waiting for %s", what);
            errors++;
        end
        step();
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            $display("FAIL %s expected %h got %h", name, 1'b0, value);
            errors++;
        end
    endtask

    task automatic load_weights(input int w0, input int w1, input int w2);
        kern[0]        = w0;
        kern[1]        = w1;
        kern[2]        = w2;
        weight_data.w0 = quad_data_pkg::weight_t'(w0);
        weight_data.w1 = quad_data_pkg::weight_t'(w1);
        weight_data.w2 = quad_data_pkg::weight_t'(w2);
        weight_valid   = 1'b1;
        wait_for(0, "weight_ready");
        weight_valid   = 1'b0;
    endtask

    // Reference model, then the whole job up to the acknowledge
    task automatic run_job(input int n, input bit relu, input bit gaps, input bit noise);
        int i;
        int s;
        int act[0:15];
        for (i = 0; i < n; i++) begin
            act[i] = (relu && pix[i] < 0) ? 0 : pix[i];
        end
        for (i = 0; i + `QUAD_NUM_TAPS <= n; i++) begin
            s = kern[0] * act[i] + kern[1] * act[i + 1] + kern[2] * act[i + 2];
            if (s > 32767) begin
                s = 32767;
            end else if (s < -32768) begin
                s = -32768;
            end
            expected_q.push_back(quad_data_pkg::result_t'(s));
        end
        job_parameters.num_pixels  = `QUAD_COUNT_WIDTH'(n);
        job_parameters.relu_enable = relu;
        job_start = 1'b1;
        step();
        job_start = 1'b0;
        // Kernel writes offered from the accept to the acknowledge must be refused
        if (noise) begin
            weight_valid = 1'b1;
            weight_data  = 24'($random(seed));
        end
        wait_for(2, "job_accept");
        for (i = 0; i < n; i++) begin
            if (gaps) begin
                pixel_valid = 1'b0;
                pixel_data  = 8'($random(seed));
                repeat ($unsigned($random(seed)) % 4) step();
            end
            pixel_valid = 1'b1;
            pixel_data  = quad_data_pkg::pixel_t'(pix[i]);
            wait_for(1, "pixel_ready");
        end
        pixel_valid  = 1'b0;
        wait_for(3, "job_complete");
        if (expected_q.size() != 0) begin
            $display("%0d expected results never arrived", expected_q.size());
            errors++;
            expected_q.delete();
        end
        job_complete_ack = 1'b1;
        step();
        job_complete_ack = 1'b0;
        weight_valid     = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, total_errors() - errors_before);
        end
        errors_before = total_errors();
    endtask

    //////////////////////////////
    // Result checker
    //////////////////////////////

    always @(negedge clk_core) begin
        if (!rst && result_valid) begin
            if (expected_q.size() == 0) begin
                $display("Result arrived while none was expected");
                errors++;
            end else begin
                exp_val = expected_q.pop_front();
                assert (result_data === exp_val) else begin
                    $display("FAIL result_data expected %h got %h", exp_val, result_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk_core);
        $display("Simulation ran past its cycle limit");
        $display("Something failed");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int i;
        seed             = 26581;
        errors           = 0;
        tests_run        = 0;
        tests_bad        = 0;
        errors_before    = 0;
        job_start        = 1'b0;
        job_parameters   = '0;
        job_complete_ack = 1'b0;
        weight_valid     = 1'b0;
        weight_data      = '0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;

        wait_for(4, "reset release");
        @(negedge clk_core);
        check_low("job_accept", job_accept);
        check_low("job_complete", job_complete);
        check_low("pixel_ready", pixel_ready);
        check_low("weight_ready", weight_ready);
        check_low("result_valid", result_valid);
        step();
        end_test("reset state");

        load_weights(rand_byte(), rand_byte(), rand_byte());
        for (i = 0; i < 8; i++) begin
            pix[i] = rand_byte();
        end
        run_job(8, 1'b0, 1'b0, 1'b0);
        end_test("random pixels without ReLU");

        // Three of every four pixels forced negative
        load_weights(rand_byte(), rand_byte(), rand_byte());
        for (i = 0; i < 10; i++) begin
            pix[i] = rand_byte();
            if (i % 4 != 3 && pix[i] >= 0) begin
                pix[i] = pix[i] - 128;
            end
        end
        run_job(10, 1'b1, 1'b0, 1'b0);
        end_test("ReLU on negative pixels");

        load_weights(127, 127, 127);
        pix[0] = 127;
        pix[1] = 127;
        pix[2] = 127;
        pix[3] = -128;
        pix[4] = -128;
        pix[5] = -128;
        run_job(6, 1'b0, 1'b0, 1'b0);
        end_test("saturation at both limits");

        // Back-to-back jobs, then one too short for a window
        load_weights(rand_byte(), rand_byte(), rand_byte());
        for (i = 0; i < 9; i++) begin
            pix[i] = rand_byte();
        end
        run_job(9, 1'b0, 1'b1, 1'b1);
        for (i = 0; i < 7; i++) begin
            pix[i] = rand_byte();
        end
        run_job(7, 1'b1, 1'b1, 1'b0);
        pix[0] = rand_byte();
        pix[1] = rand_byte();
        run_job(2, 1'b0, 1'b0, 1'b0);
        end_test("gaps and consecutive jobs");

        $display("%0d tests run, %0d with errors, %0d errors in all",
                 tests_run, tests_bad, total_errors());
        if (total_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
